// ==== img_dma_pkg.sv ====
package img_dma_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int PIXEL_W = 32;  // pixel and bus data width
	localparam int BUF_AW  = 12;  // buffer index width, block <= 4096 pixels

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [31:0]        addr_t;     // byte address
	typedef logic [BUF_AW-1:0]  buf_addr_t;

	////////////////////////////////////////
	// job and bus command
	////////////////////////////////////////
	typedef struct packed {
		addr_t      in_base;       // source image base
		addr_t      out_base;      // result image base
		addr_t      start_offset;  // byte offset added on both sides
		logic [3:0] num_blocks;
	} job_t;

	typedef struct packed {
		logic  rd_req;
		logic  wr_req;
		addr_t addr;
	} mst_cmd_t;

	////////////////////////////////////////
	// pixel buffer ports
	////////////////////////////////////////
	typedef struct packed {
		logic      en;
		buf_addr_t addr;
		pixel_t    data;
	} buf_wr_t;

	typedef struct packed {
		logic      en;
		buf_addr_t addr;
	} buf_rd_t;

endpackage

// ==== pixel_ram.sv ====
`timescale 1ns/1ps

module pixel_ram #(
	parameter int DEPTH = 64  // one block of pixels
) (
	input  logic                 Clk,
	input  img_dma_pkg::buf_wr_t wr,
	input  img_dma_pkg::buf_rd_t rd,
	output img_dma_pkg::pixel_t  rd_data
);
	import img_dma_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // used index bits

	pixel_t mem [0:DEPTH-1];

	// write port and registered read port, read holds when not enabled
	always_ff @(posedge Clk) begin
		if (wr.en) mem[wr.addr[AW-1:0]] <= wr.data;
		if (rd.en) rd_data <= mem[rd.addr[AW-1:0]];
	end

endmodule

// ==== burst_reader.sv ====
`timescale 1ns/1ps

module burst_reader (
	input  logic                 Clk,
	input  logic                 rst_n,
	input  logic                 blk_start,     // restart at index 0
	input  img_dma_pkg::pixel_t  rd_data,
	input  logic                 rd_src_rdy_n,  // beat valid, active low
	output img_dma_pkg::buf_wr_t in_wr
);
	import img_dma_pkg::*;

	pixel_t    beat_q;    // captured read beat
	logic      beat_vld;
	buf_addr_t wr_idx;    // runs across all bursts of a block

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_vld <= 1'b0;
			wr_idx   <= '0;
		end else begin
			beat_vld <= !rd_src_rdy_n;  // always ready, so every low cycle is a beat
			if (blk_start) wr_idx <= '0;
			else if (beat_vld) wr_idx <= wr_idx + 1'b1;  // step after each write
		end
	end

	always_ff @(posedge Clk) begin
		if (!rd_src_rdy_n) beat_q <= rd_data;
	end

	// buffer write one cycle after the beat
	assign in_wr.en   = beat_vld;
	assign in_wr.addr = wr_idx;
	assign in_wr.data = beat_q;

endmodule

// ==== stream_port.sv ====
`timescale 1ns/1ps

module stream_port #(
	parameter int BLOCK_PIXELS = 64
) (
	input  logic                 Clk,
	input  logic                 rst_n,
	input  logic                 stream_start,
	output img_dma_pkg::buf_rd_t in_rd,
	input  img_dma_pkg::pixel_t  in_data,      // input buffer read data
	output logic                 m_valid,
	output img_dma_pkg::pixel_t  m_data,
	input  logic                 m_ready,
	input  logic                 s_valid,
	input  img_dma_pkg::pixel_t  s_data,
	output logic                 s_ready,
	output img_dma_pkg::buf_wr_t out_wr,
	output logic                 stream_done
);
	import img_dma_pkg::*;

	localparam int CNT_W = (BLOCK_PIXELS > 1) ? $clog2(BLOCK_PIXELS) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BLOCK_PIXELS - 1);

	logic             tx_busy;   // words left to send
	logic             rx_busy;   // results left to capture
	logic             running;   // between start and done
	logic [CNT_W-1:0] send_cnt;
	logic [CNT_W-1:0] recv_cnt;
	logic             rd_go;
	logic             s_fire;

	////////////////////////////////////////
	// send side
	////////////////////////////////////////
	// next read only when the word on m_data is free or leaving
	assign rd_go      = tx_busy && (!m_valid || m_ready);
	assign in_rd.en   = rd_go;
	assign in_rd.addr = buf_addr_t'(send_cnt);
	assign m_data     = in_data;  // ram output register holds the word while stalled

	////////////////////////////////////////
	// receive side
	////////////////////////////////////////
	assign s_ready     = rx_busy;
	assign s_fire      = s_valid && s_ready;
	assign out_wr.en   = s_fire;
	assign out_wr.addr = buf_addr_t'(recv_cnt);
	assign out_wr.data = s_data;

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy     <= 1'b0;
			rx_busy     <= 1'b0;
			running     <= 1'b0;
			send_cnt    <= '0;
			recv_cnt    <= '0;
			m_valid     <= 1'b0;
			stream_done <= 1'b0;
		end else begin
			stream_done <= 1'b0;
			if (stream_start) begin
				tx_busy  <= 1'b1;
				rx_busy  <= 1'b1;
				running  <= 1'b1;
				send_cnt <= '0;
				recv_cnt <= '0;
			end else begin
				if (rd_go) begin
					send_cnt <= send_cnt + 1'b1;
					if (send_cnt == LAST_CNT) tx_busy <= 1'b0;  // last word read
				end
				if (s_fire) begin
					recv_cnt <= recv_cnt + 1'b1;
					if (recv_cnt == LAST_CNT) rx_busy <= 1'b0;
				end
				// finished once all sent, all captured and m_data drained
				if (running && !tx_busy && !rx_busy && !m_valid) begin
					running     <= 1'b0;
					stream_done <= 1'b1;
				end
			end
			if (rd_go) m_valid <= 1'b1;  // data shows up next cycle
			else if (m_ready) m_valid <= 1'b0;
		end
	end

endmodule

// ==== burst_writer.sv ====
`timescale 1ns/1ps

module burst_writer #(
	parameter int BURST_BEATS = 16
) (
	input  logic                 Clk,
	input  logic                 rst_n,
	input  logic                 blk_start,
	input  logic                 wr_burst_go,   // burst acked by the bus
	output img_dma_pkg::buf_rd_t out_rd,
	input  img_dma_pkg::pixel_t  out_data,      // output buffer read data
	output img_dma_pkg::pixel_t  wr_data,
	output logic                 wr_src_rdy_n,
	output logic                 wr_sof_n,
	output logic                 wr_eof_n,
	input  logic                 wr_dst_rdy_n
);
	import img_dma_pkg::*;

	localparam int BEAT_W = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_BEATS - 1);

	logic              load_q;    // first beat arrives from the buffer
	logic [BEAT_W-1:0] beat_cnt;  // beat on the bus now
	logic [BEAT_W-1:0] rd_left;   // buffer reads still owed this burst
	buf_addr_t         rd_idx;    // continues across bursts of a block
	logic              fire;
	logic              last;

	assign fire = !wr_src_rdy_n && !wr_dst_rdy_n;
	assign last = (beat_cnt == LAST_BEAT);

	////////////////////////////////////////
	// buffer read ahead
	////////////////////////////////////////
	// first read on go, then one more per loaded beat
	assign out_rd.en   = wr_burst_go || ((load_q || fire) && rd_left != '0);
	assign out_rd.addr = rd_idx;

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			load_q  <= 1'b0;
			rd_left <= '0;
			rd_idx  <= '0;
		end else begin
			load_q <= wr_burst_go;
			if (blk_start) rd_idx <= '0;
			else if (out_rd.en) rd_idx <= rd_idx + 1'b1;
			if (wr_burst_go) rd_left <= LAST_BEAT;  // go covers beat 0
			else if (out_rd.en) rd_left <= rd_left - 1'b1;
		end
	end

	// held beat, next one sits in the buffer output register
	always_ff @(posedge Clk) begin
		if (load_q || (fire && !last)) wr_data <= out_data;
	end

	////////////////////////////////////////
	// beat count and frame markers
	////////////////////////////////////////
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt     <= '0;
			wr_src_rdy_n <= 1'b1;
			wr_sof_n     <= 1'b1;
			wr_eof_n     <= 1'b1;
		end else if (load_q) begin
			beat_cnt     <= '0;
			wr_src_rdy_n <= 1'b0;  // two cycles after go
			wr_sof_n     <= 1'b0;
			wr_eof_n     <= (BURST_BEATS != 1);  // single-beat burst is also the last
		end else if (fire) begin
			beat_cnt <= beat_cnt + 1'b1;
			wr_sof_n <= 1'b1;
			if (last) begin
				wr_src_rdy_n <= 1'b1;  // burst complete
				wr_eof_n     <= 1'b1;
			end else begin
				wr_eof_n <= (beat_cnt + 1'b1 != LAST_BEAT);  // low with the final beat
			end
		end
	end

endmodule

// ==== block_sequencer.sv ====
`timescale 1ns/1ps

module block_sequencer #(
	parameter int BLOCK_PIXELS = 64,
	parameter int BURST_BEATS  = 16
) (
	input  logic                  Clk,
	input  logic                  rst_n,
	input  logic                  begin_op,     // level, looked at only in idle
	input  img_dma_pkg::job_t     job,
	input  logic                  cmd_ack,
	input  logic                  cmd_cmplt,
	input  logic                  stream_done,
	output img_dma_pkg::mst_cmd_t mst_cmd,
	output logic                  blk_start,
	output logic                  stream_start,
	output logic                  wr_burst_go,
	output logic                  done
);
	import img_dma_pkg::*;

	localparam int REQS        = BLOCK_PIXELS / BURST_BEATS;  // requests per block
	localparam int REQ_W       = (REQS > 1) ? $clog2(REQS) : 1;
	localparam int BLOCK_BYTES = BLOCK_PIXELS * PIXEL_W / 8;
	localparam int BURST_BYTES = BURST_BEATS * PIXEL_W / 8;
	localparam logic [REQ_W-1:0] LAST_REQ = REQ_W'(REQS - 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_RD_REQ,    // raise read request
		S_RD_ACK,    // hold until acked
		S_RD_CMPLT,  // beats arriving
		S_STREAM,    // compute engine exchange
		S_WR_REQ,
		S_WR_ACK,
		S_WR_CMPLT,
		S_END        // done is high here
	} state_t;

	state_t           state;
	job_t             job_q;
	logic [3:0]       blk_cnt;
	logic [REQ_W-1:0] req_cnt;  // request within block
	addr_t            blk_off;
	addr_t            req_off;
	addr_t            rd_addr;
	addr_t            wr_addr;
	logic             last_req;
	logic             last_blk;

	////////////////////////////////////////
	// byte address of the current request
	////////////////////////////////////////
	assign blk_off  = addr_t'(blk_cnt) * addr_t'(BLOCK_BYTES);
	assign req_off  = addr_t'(req_cnt) * addr_t'(BURST_BYTES);
	assign rd_addr  = job_q.in_base + job_q.start_offset + blk_off + req_off;
	assign wr_addr  = job_q.out_base + job_q.start_offset + blk_off + req_off;
	assign last_req = (req_cnt == LAST_REQ);
	assign last_blk = (blk_cnt == job_q.num_blocks - 4'd1);

	always_ff @(posedge Clk) begin
		if (state == S_IDLE && begin_op) job_q <= job;  // job stays fixed till done
	end

	////////////////////////////////////////
	// main FSM
	////////////////////////////////////////
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= S_IDLE;
			blk_cnt      <= '0;
			req_cnt      <= '0;
			mst_cmd      <= '0;
			blk_start    <= 1'b0;
			stream_start <= 1'b0;
			wr_burst_go  <= 1'b0;
			done         <= 1'b0;
		end else begin
			// phase pulses are one cycle wide
			blk_start    <= 1'b0;
			stream_start <= 1'b0;
			wr_burst_go  <= 1'b0;
			done         <= 1'b0;
			case (state)
				S_IDLE: begin
					if (begin_op) begin
						blk_cnt   <= '0;
						req_cnt   <= '0;
						blk_start <= 1'b1;  // first block
						state     <= S_RD_REQ;
					end
				end
				S_RD_REQ: begin
					mst_cmd.rd_req <= 1'b1;
					mst_cmd.addr   <= rd_addr;
					state          <= S_RD_ACK;
				end
				S_RD_ACK: begin
					if (cmd_ack) begin
						mst_cmd.rd_req <= 1'b0;
						state          <= S_RD_CMPLT;
					end
				end
				S_RD_CMPLT: begin
					if (cmd_cmplt) begin
						if (last_req) begin  // whole block in the input buffer
							req_cnt      <= '0;
							stream_start <= 1'b1;
							state        <= S_STREAM;
						end else begin
							req_cnt <= req_cnt + 1'b1;
							state   <= S_RD_REQ;
						end
					end
				end
				S_STREAM: begin
					if (stream_done) state <= S_WR_REQ;
				end
				S_WR_REQ: begin
					mst_cmd.wr_req <= 1'b1;
					mst_cmd.addr   <= wr_addr;
					state          <= S_WR_ACK;
				end
				S_WR_ACK: begin
					if (cmd_ack) begin
						mst_cmd.wr_req <= 1'b0;
						wr_burst_go    <= 1'b1;  // writer starts its beats
						state          <= S_WR_CMPLT;
					end
				end
				S_WR_CMPLT: begin
					if (cmd_cmplt) begin
						if (!last_req) begin
							req_cnt <= req_cnt + 1'b1;
							state   <= S_WR_REQ;
						end else if (last_blk) begin
							done  <= 1'b1;  // one cycle after final cmplt
							state <= S_END;
						end else begin
							blk_cnt   <= blk_cnt + 1'b1;
							req_cnt   <= '0;
							blk_start <= 1'b1;
							state     <= S_RD_REQ;
						end
					end
				end
				S_END: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== image_block_mover.sv ====
`timescale 1ns/1ps

module image_block_mover #(
	parameter int BLOCK_PIXELS = 64,  // pixels per block
	parameter int BURST_BEATS  = 16   // beats per bus request
) (
	input  logic                  Clk,
	input  logic                  rst_n,
	input  logic                  begin_op,
	input  img_dma_pkg::job_t     job,
	output logic                  done,
	output img_dma_pkg::mst_cmd_t mst_cmd,
	input  logic                  cmd_ack,
	input  logic                  cmd_cmplt,
	input  img_dma_pkg::pixel_t   rd_data,
	input  logic                  rd_src_rdy_n,
	output img_dma_pkg::pixel_t   wr_data,
	output logic                  wr_src_rdy_n,
	output logic                  wr_sof_n,
	output logic                  wr_eof_n,
	input  logic                  wr_dst_rdy_n,
	output logic                  m_valid,
	output img_dma_pkg::pixel_t   m_data,
	input  logic                  m_ready,
	input  logic                  s_valid,
	input  img_dma_pkg::pixel_t   s_data,
	output logic                  s_ready
);
	import img_dma_pkg::*;

	logic    blk_start;     // new block, clear buffer indices
	logic    stream_start;
	logic    stream_done;
	logic    wr_burst_go;   // one write burst granted
	buf_wr_t in_wr;
	buf_rd_t in_rd;
	buf_wr_t out_wr;
	buf_rd_t out_rd;
	pixel_t  in_rd_data;
	pixel_t  out_rd_data;

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	block_sequencer #(
		.BLOCK_PIXELS(BLOCK_PIXELS),
		.BURST_BEATS (BURST_BEATS)
	) block_sequencer_i (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.begin_op    (begin_op),
		.job         (job),
		.cmd_ack     (cmd_ack),
		.cmd_cmplt   (cmd_cmplt),
		.stream_done (stream_done),
		.mst_cmd     (mst_cmd),
		.blk_start   (blk_start),
		.stream_start(stream_start),
		.wr_burst_go (wr_burst_go),
		.done        (done)
	);

	////////////////////////////////////////
	// pixel buffers
	////////////////////////////////////////
	pixel_ram #(.DEPTH(BLOCK_PIXELS)) in_buf_i (
		.Clk    (Clk),
		.wr     (in_wr),
		.rd     (in_rd),
		.rd_data(in_rd_data)
	);

	pixel_ram #(.DEPTH(BLOCK_PIXELS)) out_buf_i (
		.Clk    (Clk),
		.wr     (out_wr),
		.rd     (out_rd),
		.rd_data(out_rd_data)
	);

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////
	burst_reader burst_reader_i (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.blk_start   (blk_start),
		.rd_data     (rd_data),
		.rd_src_rdy_n(rd_src_rdy_n),
		.in_wr       (in_wr)
	);

	stream_port #(.BLOCK_PIXELS(BLOCK_PIXELS)) stream_port_i (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.stream_start(stream_start),
		.in_rd       (in_rd),
		.in_data     (in_rd_data),
		.m_valid     (m_valid),
		.m_data      (m_data),
		.m_ready     (m_ready),
		.s_valid     (s_valid),
		.s_data      (s_data),
		.s_ready     (s_ready),
		.out_wr      (out_wr),
		.stream_done (stream_done)
	);

	burst_writer #(.BURST_BEATS(BURST_BEATS)) burst_writer_i (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.blk_start   (blk_start),
		.wr_burst_go (wr_burst_go),
		.out_rd      (out_rd),
		.out_data    (out_rd_data),
		.wr_data     (wr_data),
		.wr_src_rdy_n(wr_src_rdy_n),
		.wr_sof_n    (wr_sof_n),
		.wr_eof_n    (wr_eof_n),
		.wr_dst_rdy_n(wr_dst_rdy_n)
	);

endmodule

// ==== tb_image_block_mover.sv ====
`timescale 1ns/1ps

module tb_image_block_mover;
	import img_dma_pkg::*;

	localparam int     BLOCK_PIXELS = 64;
	localparam int     BURST_BEATS  = 16;
	localparam int     REQS         = BLOCK_PIXELS / BURST_BEATS;  // bus requests per block
	localparam int     BLOCK_BYTES  = BLOCK_PIXELS * 4;
	localparam int     BURST_BYTES  = BURST_BEATS * 4;
	localparam int     TIMEOUT      = 20000;  // cycles allowed for any one wait
	localparam pixel_t XOR_MASK     = 32'h5a5a_0000;

	logic     Clk;
	logic     rst_n;
	logic     begin_op;
	job_t     job;
	logic     done;
	mst_cmd_t mst_cmd;
	logic     cmd_ack;
	logic     cmd_cmplt;
	pixel_t   rd_data;
	logic     rd_src_rdy_n;
	pixel_t   wr_data;
	logic     wr_src_rdy_n;
	logic     wr_sof_n;
	logic     wr_eof_n;
	logic     wr_dst_rdy_n;
	logic     m_valid;
	pixel_t   m_data;
	logic     m_ready;
	logic     s_valid;
	pixel_t   s_data;
	logic     s_ready;

	integer   seed;
	int       cyc;          // cycle number, bumped on every rising edge
	int       done_cnt;
	int       done_cyc;
	int       cmplt_cyc;    // cycle of the latest write cmplt
	bit       stress;       // random stalls on write data and stream
	bit       s_pend;       // result offered and not yet taken
	string    test_name;
	pixel_t   mem [addr_t]; // sparse memory, one word per 4-byte address
	addr_t    rd_addr_q [$];
	addr_t    wr_addr_q [$];
	pixel_t   sent_q [$];   // words taken from the stream master
	pixel_t   res_q [$];    // results still to return

	image_block_mover #(
		.BLOCK_PIXELS(BLOCK_PIXELS),
		.BURST_BEATS (BURST_BEATS)
	) image_block_mover_i (.*);

	////////////////////////////////////////
	// clock, cycle count, done monitor
	////////////////////////////////////////
	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;  // 40 ns period
	end

	initial begin
		forever begin
			@(posedge Clk);
			cyc++;
			#1;
			if (done) begin
				done_cnt++;  // a wide pulse counts more than once
				done_cyc = cyc;
			end
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic next_cycle();
		@(posedge Clk);
		#2;  // drive and sample clear of the edge
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// default memory contents, a bijection of the byte address
	function automatic pixel_t fill_word(input addr_t a);
		return (a * 32'h9e37_79b1) ^ 32'h1b87_3593;
	endfunction

	function automatic pixel_t mem_word(input addr_t a);
		if (mem.exists(a)) return mem[a];
		return fill_word(a);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s: %s expected %h, actual %h", test_name, what, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////
	// bus memory model
	////////////////////////////////////////
	task automatic read_burst(input addr_t a);
		int i;
		for (i = 0; i < BURST_BEATS; i++) begin
			rd_src_rdy_n = 1'b1;
			repeat (rand_below(3)) next_cycle();  // idle gap between beats
			rd_src_rdy_n = 1'b0;
			rd_data      = mem_word(a + 4 * i);
			next_cycle();
		end
		rd_src_rdy_n = 1'b1;
	endtask

	task automatic write_burst(input addr_t a);
		int n;
		int idle;
		n    = 0;
		idle = 0;
		while (n < BURST_BEATS) begin
			wr_dst_rdy_n = stress ? (rand_below(3) == 0) : 1'b0;
			if (!wr_src_rdy_n && !wr_dst_rdy_n) begin
				check_equal("wr_sof_n", 32'(n != 0), 32'(wr_sof_n));
				check_equal("wr_eof_n", 32'(n != BURST_BEATS - 1), 32'(wr_eof_n));
				mem[a + 4 * n] = wr_data;
				n++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT) abort_run("timed out waiting for a write data beat");
			end
			next_cycle();
		end
		wr_dst_rdy_n = 1'b1;
		check_equal("wr_src_rdy_n after last beat", 32'd1, 32'(wr_src_rdy_n));  // no extra beat
	endtask

	initial begin : bus_model
		addr_t a;
		bit    is_rd;
		forever begin
			next_cycle();
			if (mst_cmd.rd_req || mst_cmd.wr_req) begin
				is_rd = mst_cmd.rd_req;
				a     = mst_cmd.addr;
				if (is_rd) rd_addr_q.push_back(a);
				else wr_addr_q.push_back(a);
				repeat (rand_below(4)) next_cycle();  // ack latency, request held
				cmd_ack = 1'b1;
				next_cycle();
				cmd_ack = 1'b0;
				if (is_rd) read_burst(a);
				else write_burst(a);
				cmd_cmplt = 1'b1;  // right after the last beat
				if (!is_rd) cmplt_cyc = cyc;
				next_cycle();
				cmd_cmplt = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// compute engine model
	////////////////////////////////////////
	initial begin : engine_model
		forever begin
			next_cycle();
			// result side first so only words already taken come back
			if (!s_pend) begin
				if (res_q.size() > 0 && (!stress || rand_below(3) != 0)) begin
					s_valid = 1'b1;
					s_data  = res_q.pop_front();
				end else begin
					s_valid = 1'b0;
				end
			end
			s_pend  = s_valid && !s_ready;  // hold the word until taken
			m_ready = stress ? (rand_below(3) != 0) : 1'b1;
			if (m_valid && m_ready) begin
				sent_q.push_back(m_data);
				res_q.push_back(m_data ^ XOR_MASK);
			end
		end
	end

	////////////////////////////////////////
	// job runner and tests
	////////////////////////////////////////
	task automatic run_job(input addr_t in_base, input addr_t out_base,
			input addr_t offset, input int nblk);
		job_t   j;
		int     start_done;
		int     t;
		int     b;
		int     r;
		int     p;
		addr_t  off;
		pixel_t exp_px;
		mem.delete();
		rd_addr_q.delete();
		wr_addr_q.delete();
		sent_q.delete();
		start_done     = done_cnt;
		j.in_base      = in_base;
		j.out_base     = out_base;
		j.start_offset = offset;
		j.num_blocks   = 4'(nblk);
		job            = j;
		begin_op       = 1'b1;
		next_cycle();
		begin_op = 1'b0;
		job      = '0;  // latched already
		check_equal("rd_req one cycle after begin", 32'd0, 32'(mst_cmd.rd_req));
		next_cycle();
		check_equal("rd_req two cycles after begin", 32'd1, 32'(mst_cmd.rd_req));
		t = 0;
		while (done_cnt == start_done) begin
			next_cycle();
			t++;
			if (t > TIMEOUT) abort_run($sformatf("%s: timed out waiting for done", test_name));
		end
		check_equal("done cycle", 32'(cmplt_cyc + 1), 32'(done_cyc));
		repeat (4) next_cycle();
		check_equal("done pulses", 32'(start_done + 1), 32'(done_cnt));
		check_equal("results left", 32'd0, 32'(res_q.size()));
		check_equal("read requests", 32'(nblk * REQS), 32'(rd_addr_q.size()));
		check_equal("write requests", 32'(nblk * REQS), 32'(wr_addr_q.size()));
		check_equal("stream words", 32'(nblk * BLOCK_PIXELS), 32'(sent_q.size()));
		for (b = 0; b < nblk; b++) begin
			for (r = 0; r < REQS; r++) begin
				off = offset + b * BLOCK_BYTES + r * BURST_BYTES;
				check_equal("read address", in_base + off, rd_addr_q[b * REQS + r]);
				check_equal("write address", out_base + off, wr_addr_q[b * REQS + r]);
			end
			for (p = 0; p < BLOCK_PIXELS; p++) begin
				off    = offset + b * BLOCK_BYTES + p * 4;
				exp_px = fill_word(in_base + off);
				check_equal("stream data", exp_px, sent_q[b * BLOCK_PIXELS + p]);
				check_equal("pixel written", 32'd1, 32'(mem.exists(out_base + off)));
				check_equal("result pixel", exp_px ^ XOR_MASK, mem_word(out_base + off));
			end
		end
	endtask

	task automatic test_reset();
		int i;
		test_name = "reset";
		for (i = 0; i < 6; i++) begin  // begin_op stays low
			check_equal("rd_req", 32'd0, 32'(mst_cmd.rd_req));
			check_equal("wr_req", 32'd0, 32'(mst_cmd.wr_req));
			check_equal("done", 32'd0, 32'(done));
			check_equal("m_valid", 32'd0, 32'(m_valid));
			check_equal("s_ready", 32'd0, 32'(s_ready));
			check_equal("wr_src_rdy_n", 32'd1, 32'(wr_src_rdy_n));
			check_equal("wr_sof_n", 32'd1, 32'(wr_sof_n));
			check_equal("wr_eof_n", 32'd1, 32'(wr_eof_n));
			next_cycle();
		end
	endtask

	task automatic test_single_block();
		test_name = "single_block";
		stress    = 1'b0;
		run_job(32'h0001_0000, 32'h0004_0000, 32'h0, 1);
	endtask

	task automatic test_multi_block();
		test_name = "multi_block";
		stress    = 1'b0;
		run_job(32'h0002_0000, 32'h0006_0000, 32'h0000_0140, 3);  // nonzero offset
	endtask

	task automatic test_backpressure();
		test_name = "backpressure";
		stress    = 1'b1;
		run_job(32'h0003_0000, 32'h0007_0000, 32'h0000_0080, 2);
		stress = 1'b0;
	endtask

	task automatic test_back_to_back();
		test_name = "back_to_back";
		stress    = 1'b0;
		run_job(32'h0010_0000, 32'h0020_0000, 32'h0000_0040, 2);
		stress = 1'b1;
		run_job(32'h0030_0000, 32'h0040_0000, 32'h0000_0100, 2);  // new bases only
		stress = 1'b0;
	endtask

	initial begin
		seed         = 32'h81f2_8b9e;
		cyc          = 0;
		done_cnt     = 0;
		done_cyc     = 0;
		cmplt_cyc    = 0;
		stress       = 1'b0;
		s_pend       = 1'b0;
		test_name    = "init";
		rst_n        = 1'b0;
		begin_op     = 1'b0;
		job          = '0;
		cmd_ack      = 1'b0;
		cmd_cmplt    = 1'b0;
		rd_data      = '0;
		rd_src_rdy_n = 1'b1;
		wr_dst_rdy_n = 1'b1;
		m_ready      = 1'b0;
		s_valid      = 1'b0;
		s_data       = '0;
		repeat (8) @(posedge Clk);  // reset held 8 cycles
		#2;
		rst_n = 1'b1;
		next_cycle();
		test_reset();
		test_single_block();
		test_multi_block();
		test_backpressure();
		test_back_to_back();
		$display("test passed");
		$finish;
	end

endmodule

// ==== image_block_mover.f ====
img_dma_pkg.sv
pixel_ram.sv
burst_reader.sv
stream_port.sv
burst_writer.sv
block_sequencer.sv
image_block_mover.sv
tb_image_block_mover.sv

// ==== Makefile ====
# Verilator lint and simulation of the image block mover

TOP       ?= tb_image_block_mover
FILELIST  ?= image_block_mover.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
